// ==== include/alu_settings.svh ====
// ALU execute cluster settings, lane count and operand width

`ifndef ALU_SETTINGS_SVH
`define ALU_SETTINGS_SVH

// Operation slots per bundle, one ALU lane per slot
// Any value of 1 or more is supported
`define ALU_LANES 2

// Operand and result width
// Tied to the 32-bit EFLAGS layout, leave at 32
`define ALU_DATA_W 32

`endif

// ==== src/alu_ops_pkg.sv ====
// ALU opcode package, operation encoding shared by issue and the lanes

`default_nettype none

package alu_ops_pkg;

	// Opcode field width
	localparam int ALU_OP_W = 3;

	// Operation encoding, same numbering as the decoder
	typedef enum logic [ALU_OP_W-1:0] {
		// a + b, full arithmetic flags
		OP_ADD = 3'd0,
		// a | b, logic flags
		OP_OR  = 3'd1,
		// ~a, no flag written
		OP_NOT = 3'd2,
		// Decimal adjust of the low byte of a
		OP_DAA = 3'd3,
		// a & b, logic flags
		OP_AND = 3'd4,
		// Clear DF
		OP_CLD = 3'd5,
		// a - b, result returned
		OP_CMP = 3'd6,
		// Set DF
		OP_STD = 3'd7
	} alu_op_e;

endpackage

`default_nettype wire

// ==== src/eflags_pkg.sv ====
// EFLAGS package, status flag struct, bit layout and image conversion

`default_nettype none

package eflags_pkg;

	// Architectural flags image width
	localparam int EFLAGS_W = 32;

	// Bit positions inside EFLAGS
	localparam int CF_BIT    = 0;
	localparam int RSVD1_BIT = 1;
	localparam int PF_BIT    = 2;
	localparam int AF_BIT    = 4;
	localparam int ZF_BIT    = 6;
	localparam int SF_BIT    = 7;
	localparam int DF_BIT    = 10;
	localparam int OF_BIT    = 11;

	// Reset image, every flag cleared
	localparam logic [EFLAGS_W-1:0] EFLAGS_RESET = '0;

	// The seven flags the cluster tracks
	typedef struct packed {
		logic of;
		logic df;
		logic sf;
		logic zf;
		logic af;
		logic pf;
		logic cf;
	} status_flags_t;

	// Flags to 32-bit image, reserved bit 1 reads as 1
	function automatic logic [EFLAGS_W-1:0] pack_eflags(status_flags_t f);
		logic [EFLAGS_W-1:0] img;
		img = '0;
		img[RSVD1_BIT] = 1'b1;
		img[CF_BIT] = f.cf;
		img[PF_BIT] = f.pf;
		img[AF_BIT] = f.af;
		img[ZF_BIT] = f.zf;
		img[SF_BIT] = f.sf;
		img[DF_BIT] = f.df;
		img[OF_BIT] = f.of;
		return img;
	endfunction

	// 32-bit image back to the flag struct
	function automatic status_flags_t unpack_eflags(logic [EFLAGS_W-1:0] img);
		status_flags_t f;
		f.cf = img[CF_BIT];
		f.pf = img[PF_BIT];
		f.af = img[AF_BIT];
		f.zf = img[ZF_BIT];
		f.sf = img[SF_BIT];
		f.df = img[DF_BIT];
		f.of = img[OF_BIT];
		return f;
	endfunction

endpackage

`default_nettype wire

// ==== src/alu_issue.sv ====
// ALU issue register, qualifies the incoming bundle and holds it for the lanes

`timescale 1ns/1ps
`default_nettype none

`include "alu_settings.svh"

module alu_issue (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic                                   bundle_valid,
	input  logic [`ALU_LANES-1:0]                  slot_valid,
	input  alu_ops_pkg::alu_op_e [`ALU_LANES-1:0]  slot_op,
	input  logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] slot_a,
	input  logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] slot_b,
	output logic [`ALU_LANES-1:0]                  lane_en,
	output alu_ops_pkg::alu_op_e [`ALU_LANES-1:0]  lane_op,
	output logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] lane_a,
	output logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] lane_b
);
	import alu_ops_pkg::*;

	// A slot is live only with the bundle strobe
	logic [`ALU_LANES-1:0] slot_go;

	assign slot_go = slot_valid & {`ALU_LANES{bundle_valid}};

	//--------------------------------------------------------------------------
	// Lane enables
	//--------------------------------------------------------------------------

	// Idle cycle or empty bundle leaves every lane off
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			lane_en <= '0;
		end else begin
			lane_en <= slot_go;
		end
	end

	//--------------------------------------------------------------------------
	// Opcode and operand capture
	//--------------------------------------------------------------------------

	// Only live slots load, dead slots keep their old payload
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ALU_LANES; i++) begin
			if (slot_go[i]) begin
				lane_op[i] <= slot_op[i];
				lane_a[i]  <= slot_a[i];
				lane_b[i]  <= slot_b[i];
			end
		end
	end

	// Enabled lanes never see an unknown opcode
	generate
		for (genvar g = 0; g < `ALU_LANES; g++) begin : g_op_chk
			a_op_known: assert property (@(posedge clk) disable iff (!rst_n)
				lane_en[g] |-> !$isunknown(lane_op[g]));
		end
	endgenerate

endmodule

`default_nettype wire

// ==== src/alu_lane.sv ====
// ALU lane computing one slot's result and the next status flags

`timescale 1ns/1ps
`default_nettype none

`include "alu_settings.svh"

module alu_lane (
	input  logic                      en,
	input  alu_ops_pkg::alu_op_e      op,
	input  logic [`ALU_DATA_W-1:0]    a,
	input  logic [`ALU_DATA_W-1:0]    b,
	input  eflags_pkg::status_flags_t flags_in,
	output logic [`ALU_DATA_W-1:0]    result,
	output eflags_pkg::status_flags_t flags_out
);
	import alu_ops_pkg::*;
	import eflags_pkg::*;

	localparam int W = `ALU_DATA_W;

	// Sign, zero and parity from a result with parity over the low byte only
	function automatic status_flags_t set_szp(status_flags_t f, logic [W-1:0] r);
		status_flags_t o;
		o = f;
		o.sf = r[W-1];
		o.zf = (r == '0);
		o.pf = ~^r[7:0];
		return o;
	endfunction

	// Carry and borrow chains with one extra bit for the carry out
	logic [W:0]    sum;
	logic [W:0]    diff;
	logic [W-1:0]  and_res;
	logic [W-1:0]  or_res;

	// DAA adjust steps
	logic          daa_lo_adj;
	logic          daa_hi_adj;
	logic [7:0]    daa_al1;
	logic [7:0]    daa_al2;

	// Flags as if the lane were enabled
	status_flags_t f_new;

	assign sum     = {1'b0, a} + {1'b0, b};
	assign diff    = {1'b0, a} - {1'b0, b};
	assign and_res = a & b;
	assign or_res  = a | b;

	//--------------------------------------------------------------------------
	// Decimal adjust
	//--------------------------------------------------------------------------

	// Low digit above 9 or an aux carry pending
	assign daa_lo_adj = (a[3:0] > 4'd9) | flags_in.af;
	assign daa_al1    = daa_lo_adj ? (a[7:0] + 8'h06) : a[7:0];
	// High step looks at the byte before any adjust
	assign daa_hi_adj = (a[7:0] > 8'h99) | flags_in.cf;
	assign daa_al2    = daa_hi_adj ? (daa_al1 + 8'h60) : daa_al1;

	//--------------------------------------------------------------------------
	// Result and flag select
	//--------------------------------------------------------------------------

	always_comb begin
		result = '0;
		f_new  = flags_in;
		case (op)
			OP_ADD: begin
				result = sum[W-1:0];
				f_new  = set_szp(flags_in, sum[W-1:0]);
				f_new.cf = sum[W];
				// Carry out of bit 3
				f_new.af = a[4] ^ b[4] ^ sum[4];
				f_new.of = (a[W-1] == b[W-1]) && (sum[W-1] != a[W-1]);
			end
			OP_CMP: begin
				result = diff[W-1:0];
				f_new  = set_szp(flags_in, diff[W-1:0]);
				// Borrow out of the top bit
				f_new.cf = diff[W];
				f_new.af = a[4] ^ b[4] ^ diff[4];
				f_new.of = (a[W-1] != b[W-1]) && (diff[W-1] != a[W-1]);
			end
			OP_AND, OP_OR: begin
				result = (op == OP_AND) ? and_res : or_res;
				f_new  = set_szp(flags_in, result);
				f_new.of = 1'b0;
				f_new.cf = 1'b0;
				f_new.af = 1'b0;
			end
			OP_NOT: begin
				result = ~a;
			end
			OP_DAA: begin
				result = {{(W-8){1'b0}}, daa_al2};
				f_new  = set_szp(flags_in, result);
				f_new.af = daa_lo_adj;
				f_new.cf = daa_hi_adj;
				// BCD is unsigned
				f_new.sf = 1'b0;
				f_new.of = 1'b0;
			end
			OP_CLD: f_new.df = 1'b0;
			OP_STD: f_new.df = 1'b1;
			default: begin
				result = '0;
				f_new  = flags_in;
			end
		endcase
	end

	// Idle lane hands the incoming flags straight on
	assign flags_out = en ? f_new : flags_in;

endmodule

`default_nettype wire

// ==== src/alu_retire.sv ====
// ALU retire stage, registers lane results and holds the architectural flags

`timescale 1ns/1ps
`default_nettype none

`include "alu_settings.svh"

module alu_retire (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic [`ALU_LANES-1:0]                          lane_en,
	input  logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0]         lane_result,
	input  eflags_pkg::status_flags_t [`ALU_LANES-1:0]     lane_flags,
	input  eflags_pkg::status_flags_t                      last_flags,
	output logic [`ALU_LANES-1:0]                          res_valid,
	output logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0]         res_data,
	output logic [`ALU_LANES-1:0][eflags_pkg::EFLAGS_W-1:0] res_eflags,
	output eflags_pkg::status_flags_t                      flags_q,
	output logic [eflags_pkg::EFLAGS_W-1:0]                eflags
);
	import eflags_pkg::*;

	// Flags move only when the bundle did something
	logic any_en;

	assign any_en = |lane_en;

	//--------------------------------------------------------------------------
	// Architectural flags
	//--------------------------------------------------------------------------

	// flags_q feeds lane 0 of the bundle entering issue on this same edge
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res_valid <= '0;
			flags_q   <= unpack_eflags(EFLAGS_RESET);
			eflags    <= pack_eflags(unpack_eflags(EFLAGS_RESET));
		end else begin
			res_valid <= lane_en;
			if (any_en) begin
				flags_q <= last_flags;
				eflags  <= pack_eflags(last_flags);
			end
		end
	end

	//--------------------------------------------------------------------------
	// Per-slot results
	//--------------------------------------------------------------------------

	// Image after each slot, taken from that lane's flags_out
	always_ff @(posedge clk) begin
		for (int i = 0; i < `ALU_LANES; i++) begin
			if (lane_en[i]) begin
				res_data[i]   <= lane_result[i];
				res_eflags[i] <= pack_eflags(lane_flags[i]);
			end
		end
	end

	// Reserved bit holds through reset and every flag update
	a_rsvd_bit1: assert property (@(posedge clk) disable iff (!rst_n)
		eflags[RSVD1_BIT] == 1'b1);

endmodule

`default_nettype wire

// ==== src/alu_cluster.sv ====
// ALU execute cluster top, issue register, lane row with flag ripple and retire

`timescale 1ns/1ps
`default_nettype none

`include "alu_settings.svh"

module alu_cluster (
	input  logic                                           clk,
	input  logic                                           rst_n,
	input  logic                                           bundle_valid,
	input  logic [`ALU_LANES-1:0]                          slot_valid,
	input  alu_ops_pkg::alu_op_e [`ALU_LANES-1:0]          slot_op,
	input  logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0]         slot_a,
	input  logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0]         slot_b,
	output logic [`ALU_LANES-1:0]                          res_valid,
	output logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0]         res_data,
	output logic [`ALU_LANES-1:0][eflags_pkg::EFLAGS_W-1:0] res_eflags,
	output logic [eflags_pkg::EFLAGS_W-1:0]                eflags
);
	import alu_ops_pkg::*;
	import eflags_pkg::*;

	// Issue to lanes
	logic [`ALU_LANES-1:0]                  lane_en;
	alu_op_e [`ALU_LANES-1:0]               lane_op;
	logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] lane_a;
	logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] lane_b;

	// Lanes to retire
	logic [`ALU_LANES-1:0][`ALU_DATA_W-1:0] lane_result;

	// Flag ripple, entry 0 is the retired flags, entry i+1 leaves lane i
	status_flags_t [`ALU_LANES:0]           flag_chain;
	status_flags_t                          flags_q;

	assign flag_chain[0] = flags_q;

	alu_issue u_issue (
		.clk          (clk),
		.rst_n        (rst_n),
		.bundle_valid (bundle_valid),
		.slot_valid   (slot_valid),
		.slot_op      (slot_op),
		.slot_a       (slot_a),
		.slot_b       (slot_b),
		.lane_en      (lane_en),
		.lane_op      (lane_op),
		.lane_a       (lane_a),
		.lane_b       (lane_b)
	);

	// One lane per slot, later slots see earlier slots' flags
	generate
		for (genvar g = 0; g < `ALU_LANES; g++) begin : g_lane
			alu_lane u_lane (
				.en        (lane_en[g]),
				.op        (lane_op[g]),
				.a         (lane_a[g]),
				.b         (lane_b[g]),
				.flags_in  (flag_chain[g]),
				.result    (lane_result[g]),
				.flags_out (flag_chain[g+1])
			);
		end
	endgenerate

	alu_retire u_retire (
		.clk         (clk),
		.rst_n       (rst_n),
		.lane_en     (lane_en),
		.lane_result (lane_result),
		.lane_flags  (flag_chain[`ALU_LANES:1]),
		.last_flags  (flag_chain[`ALU_LANES]),
		.res_valid   (res_valid),
		.res_data    (res_data),
		.res_eflags  (res_eflags),
		.flags_q     (flags_q),
		.eflags      (eflags)
	);

endmodule

`default_nettype wire

// ==== verif/alu_cluster_tb.sv ====
// ALU cluster testbench driving directed and random bundles against a flag model

`timescale 1ns/1ps
`default_nettype none

`include "alu_settings.svh"

module alu_cluster_tb;
	import alu_ops_pkg::*;
	import eflags_pkg::*;

	localparam int L           = `ALU_LANES;
	localparam int W           = `ALU_DATA_W;
	// Bundle counts of the directed run with its idle bundles and of the random run
	localparam int N_DIRECTED  = 20;
	localparam int N_RANDOM    = 300;
	localparam int CYCLE_LIMIT = N_DIRECTED + N_RANDOM + 20;

	// Model output for one slot
	typedef struct packed {
		logic [W-1:0]  data;
		status_flags_t flags;
	} slot_ref_t;

	// One queued bundle waiting for cyc to reach due
	typedef struct packed {
		logic [31:0]                    due;
		logic [L-1:0]                   vld;
		logic [L-1:0][W-1:0]            data;
		logic [L-1:0][EFLAGS_W-1:0]     img;
		logic [EFLAGS_W-1:0]            arch;
	} exp_entry_t;

	logic                          clk;
	logic                          rst_n;
	logic                          bundle_valid;
	logic [L-1:0]                  slot_valid;
	alu_op_e [L-1:0]               slot_op;
	logic [L-1:0][W-1:0]           slot_a;
	logic [L-1:0][W-1:0]           slot_b;
	logic [L-1:0]                  res_valid;
	logic [L-1:0][W-1:0]           res_data;
	logic [L-1:0][EFLAGS_W-1:0]    res_eflags;
	logic [EFLAGS_W-1:0]           eflags;

	// Staged slots for the next issue_bundle call
	logic [L-1:0]                  stg_valid;
	alu_op_e [L-1:0]               stg_op;
	logic [L-1:0][W-1:0]           stg_a;
	logic [L-1:0][W-1:0]           stg_b;

	status_flags_t                 model_flags;
	exp_entry_t                    exp_q[$];
	int                            cyc;
	int                            data_errs;
	int                            image_errs;
	int                            valid_errs;
	logic [31:0]                   rng;

	alu_cluster dut_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.bundle_valid (bundle_valid),
		.slot_valid   (slot_valid),
		.slot_op      (slot_op),
		.slot_a       (slot_a),
		.slot_b       (slot_b),
		.res_valid    (res_valid),
		.res_data     (res_data),
		.res_eflags   (res_eflags),
		.eflags       (eflags)
	);

	always #4 clk = ~clk;

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	function automatic logic [31:0] xorshift32(logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// PF is set for an even count of ones in the low byte
	function automatic logic low_byte_parity(logic [7:0] v);
		int n;
		n = 0;
		for (int k = 0; k < 8; k++) begin
			if (v[k])
				n++;
		end
		return (n % 2) == 0;
	endfunction

	// Flag struct to EFLAGS layout with bit 1 always set
	function automatic logic [EFLAGS_W-1:0] to_image(status_flags_t f);
		logic [EFLAGS_W-1:0] img;
		img = 32'h0000_0002;
		img[CF_BIT] = f.cf;
		img[PF_BIT] = f.pf;
		img[AF_BIT] = f.af;
		img[ZF_BIT] = f.zf;
		img[SF_BIT] = f.sf;
		img[DF_BIT] = f.df;
		img[OF_BIT] = f.of;
		return img;
	endfunction

	function automatic slot_ref_t ref_slot(status_flags_t f, alu_op_e op,
			logic [W-1:0] a, logic [W-1:0] b);
		slot_ref_t   r;
		logic [W:0]  wide;
		logic [W:0]  sw;
		logic [7:0]  al;
		logic        lo;
		logic        hi;
		r.data  = '0;
		r.flags = f;
		case (op)
			OP_ADD: begin
				wide       = a + b;
				r.data     = wide[W-1:0];
				r.flags.cf = wide[W];
				r.flags.af = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
				// Signed sum out of range when the two top bits of the extended sum differ
				sw         = {a[W-1], a} + {b[W-1], b};
				r.flags.of = sw[W] ^ sw[W-1];
			end
			OP_CMP: begin
				r.data     = a - b;
				// Borrow when a is below b as unsigned
				r.flags.cf = a < b;
				r.flags.af = a[3:0] < b[3:0];
				sw         = {a[W-1], a} - {b[W-1], b};
				r.flags.of = sw[W] ^ sw[W-1];
			end
			OP_AND, OP_OR: begin
				r.data     = (op == OP_AND) ? (a & b) : (a | b);
				r.flags.of = 1'b0;
				r.flags.cf = 1'b0;
				r.flags.af = 1'b0;
			end
			OP_NOT: r.data = ~a;
			OP_DAA: begin
				al = a[7:0];
				lo = (al[3:0] > 4'd9) || f.af;
				hi = (al > 8'h99) || f.cf;
				if (lo)
					al = al + 8'h06;
				if (hi)
					al = al + 8'h60;
				r.data     = {24'h0, al};
				r.flags.af = lo;
				r.flags.cf = hi;
				r.flags.of = 1'b0;
			end
			OP_CLD: r.flags.df = 1'b0;
			OP_STD: r.flags.df = 1'b1;
			default: r.data = '0;
		endcase
		// Common SZP for every op that writes them
		if (op == OP_ADD || op == OP_CMP || op == OP_AND || op == OP_OR || op == OP_DAA) begin
			r.flags.sf = (op == OP_DAA) ? 1'b0 : r.data[W-1];
			r.flags.zf = (r.data == '0);
			r.flags.pf = low_byte_parity(r.data[7:0]);
		end
		return r;
	endfunction

	// ------------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------------

	task automatic clear_slots();
		stg_valid = '0;
		for (int i = 0; i < L; i++) begin
			stg_op[i] = OP_ADD;
			stg_a[i]  = '0;
			stg_b[i]  = '0;
		end
	endtask

	// Slots beyond the lane count are ignored
	task automatic set_slot(int idx, alu_op_e op, logic [W-1:0] a, logic [W-1:0] b);
		if (idx < L) begin
			stg_valid[idx] = 1'b1;
			stg_op[idx]    = op;
			stg_a[idx]     = a;
			stg_b[idx]     = b;
		end
	endtask

	// Drive one bundle 1 ns after the edge and queue what must come out
	task automatic issue_bundle(logic bv);
		exp_entry_t e;
		slot_ref_t  r;
		@(posedge clk);
		#1;
		bundle_valid = bv;
		slot_valid   = stg_valid;
		slot_op      = stg_op;
		slot_a       = stg_a;
		slot_b       = stg_b;
		e     = '0;
		e.due = cyc + 2;
		for (int i = 0; i < L; i++) begin
			if (bv && stg_valid[i]) begin
				r           = ref_slot(model_flags, stg_op[i], stg_a[i], stg_b[i]);
				model_flags = r.flags;
				e.vld[i]    = 1'b1;
				e.data[i]   = r.data;
				e.img[i]    = to_image(r.flags);
			end
		end
		e.arch = to_image(model_flags);
		exp_q.push_back(e);
		clear_slots();
	endtask

	// ------------------------------------------------------------------------
	// Compare tasks and checker
	// ------------------------------------------------------------------------

	task automatic check_data(logic [W-1:0] got, logic [W-1:0] exp, int lane);
		if (got !== exp) begin
			data_errs++;
			$display("error %0t: res_data lane %0d is %h, expected %h", $time, lane, got, exp);
		end
	endtask

	task automatic check_image(logic [EFLAGS_W-1:0] got, logic [EFLAGS_W-1:0] exp,
			string what, int lane);
		if (got !== exp) begin
			image_errs++;
			$display("error %0t: %s lane %0d is %h, expected %h", $time, what, lane, got, exp);
		end
	endtask

	task automatic check_valid(logic [L-1:0] got, logic [L-1:0] exp);
		if (got !== exp) begin
			valid_errs++;
			$display("error %0t: res_valid is %b, expected %b", $time, got, exp);
		end
	endtask

	// Outputs settle after the rising edge and are sampled on the falling one
	always @(negedge clk) begin : compare_proc
		exp_entry_t e;
		if (rst_n) begin
			while (exp_q.size() > 0 && exp_q[0].due == cyc) begin
				e = exp_q.pop_front();
				check_valid(res_valid, e.vld);
				for (int i = 0; i < L; i++) begin
					if (e.vld[i]) begin
						check_data(res_data[i], e.data[i], i);
						check_image(res_eflags[i], e.img[i], "res_eflags", i);
					end
				end
				check_image(eflags, e.arch, "eflags", -1);
			end
		end
	end

	// Watchdog
	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc == CYCLE_LIMIT) begin
			$display("Timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Simulation failed");
			$finish;
		end
	end

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial begin : main_seq
		logic [EFLAGS_W-1:0] rst_img;
		logic                bv;
		logic [31:0]         ra;
		logic [31:0]         rb;
		clk          = 1'b0;
		rst_n        = 1'b0;
		bundle_valid = 1'b0;
		cyc          = 0;
		data_errs    = 0;
		image_errs   = 0;
		valid_errs   = 0;
		rng          = 32'd24;
		model_flags  = '0;
		clear_slots();
		slot_valid   = '0;
		slot_op      = stg_op;
		slot_a       = '0;
		slot_b       = '0;
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;

		// Idle state out of reset
		@(negedge clk);
		rst_img = EFLAGS_RESET;
		rst_img[RSVD1_BIT] = 1'b1;
		check_valid(res_valid, '0);
		check_image(eflags, rst_img, "eflags after reset", -1);

		// Overflow, carry, borrow, zero and parity edges
		set_slot(0, OP_ADD, 32'h7FFF_FFFF, 32'h1);
		set_slot(1, OP_ADD, 32'hFFFF_FFFF, 32'h1);
		issue_bundle(1'b1);
		set_slot(0, OP_CMP, 32'h5, 32'h7);
		set_slot(1, OP_CMP, 32'h8000_0000, 32'h1);
		issue_bundle(1'b1);
		set_slot(0, OP_CMP, 32'h1234, 32'h1234);
		set_slot(1, OP_AND, 32'hF0F0_F0F0, 32'h0F0F_0F0F);
		issue_bundle(1'b1);
		set_slot(0, OP_OR, 32'h8000_0003, 32'h0);
		set_slot(1, OP_AND, 32'hFF, 32'h07);
		issue_bundle(1'b1);
		set_slot(0, OP_ADD, 32'hF, 32'h1);
		set_slot(1, OP_OR, 32'h0, 32'h0);
		issue_bundle(1'b1);

		// DF ops, NOT, and DF through arithmetic
		set_slot(0, OP_STD, 32'h0, 32'h0);
		set_slot(1, OP_NOT, 32'h1234, 32'h0);
		issue_bundle(1'b1);
		set_slot(0, OP_ADD, 32'hFFFF_FFFF, 32'h2);
		set_slot(1, OP_CMP, 32'h1, 32'h2);
		issue_bundle(1'b1);
		set_slot(0, OP_NOT, 32'h0, 32'h0);
		set_slot(1, OP_CLD, 32'h0, 32'h0);
		issue_bundle(1'b1);
		set_slot(0, OP_STD, 32'h0, 32'h0);
		issue_bundle(1'b1);

		// BCD add then DAA in one bundle and across bundles
		set_slot(0, OP_ADD, 32'h38, 32'h49);
		set_slot(1, OP_DAA, 32'h81, 32'h0);
		issue_bundle(1'b1);
		set_slot(0, OP_ADD, 32'hFFFF_FF99, 32'h99);
		issue_bundle(1'b1);
		set_slot(0, OP_DAA, 32'h132, 32'h0);
		set_slot(1, OP_DAA, 32'h98, 32'h0);
		issue_bundle(1'b1);
		set_slot(0, OP_ADD, 32'h25, 32'h48);
		set_slot(1, OP_DAA, 32'h6D, 32'h0);
		issue_bundle(1'b1);
		// Slots marked valid but no bundle strobe
		set_slot(0, OP_STD, 32'h0, 32'h0);
		set_slot(1, OP_ADD, 32'h7FFF_FFFF, 32'h7FFF_FFFF);
		issue_bundle(1'b0);
		set_slot(0, OP_DAA, 32'h9A, 32'h0);
		issue_bundle(1'b1);

		// Empty and partial bundles
		issue_bundle(1'b1);
		set_slot(1, OP_ADD, 32'h1, 32'h1);
		issue_bundle(1'b1);
		issue_bundle(1'b0);

		// Random back-to-back bundles
		for (int n = 0; n < N_RANDOM; n++) begin
			rng = xorshift32(rng);
			bv  = (rng[2:0] != 3'd0);
			for (int i = 0; i < L; i++) begin
				rng = xorshift32(rng);
				ra  = xorshift32(rng);
				rb  = xorshift32(ra);
				// Small operands now and then for BCD and nibble carries
				if (rb[0]) begin
					ra = ra & 32'hFF;
					rb = rb & 32'hFF;
				end
				if (rng[3] | rng[4])
					set_slot(i, alu_op_e'(rng[2:0]), ra, rb);
				rng = rb;
			end
			issue_bundle(bv);
		end
		issue_bundle(1'b0);

		while (exp_q.size() > 0)
			@(negedge clk);
		#1;
		$display("Errors: data %0d, eflags %0d, valid %0d", data_errs, image_errs, valid_errs);
		if (data_errs + image_errs + valid_errs == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+include
src/alu_ops_pkg.sv
src/eflags_pkg.sv
src/alu_issue.sv
src/alu_lane.sv
src/alu_retire.sv
src/alu_cluster.sv
verif/alu_cluster_tb.sv
